// File: rtl/phasor_pkg.sv
// phasor types: angle union, output sample, table word, fold and lookup structs, result pair
package phasor_pkg;

    // default angle width, 512 codes per turn
    localparam int ANGLE_BITS_DEFAULT = 9;

    // table index covers 0 to 45 degrees inclusive in steps of two codes
    localparam int INDEX_BITS = ANGLE_BITS_DEFAULT - 3;

    // two's complement, 16384 is 1.0
    typedef logic signed [15:0] sample_t;

    // unsigned table magnitude
    typedef logic [14:0] table_word_t;

    typedef struct packed {
        logic [2:0]                    octant;
        logic [ANGLE_BITS_DEFAULT-4:0] pos;
    } octant_view_t;

    // same angle word, read as a number or as octant plus position
    typedef union packed {
        logic [ANGLE_BITS_DEFAULT-1:0] raw;
        octant_view_t                  oct;
    } phase_u;

    typedef struct packed {
        logic [INDEX_BITS-1:0] index;
        logic                  use_cos;
        logic                  positive;
        logic                  unity;
    } fold_t;

    // lower and upper neighbour of one lookup
    typedef struct packed {
        fold_t lo;
        fold_t hi;
        logic  is_sine;
    } lookup_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } result_t;

endpackage

// File: rtl/apb_pkg.sv
// APB request and response structs and the phasor register map
package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [3:0] REG_ANGLE  = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_RESULT = 4'h8;

    // status bits
    localparam int STATUS_DONE = 0;
    localparam int STATUS_BUSY = 1;

endpackage

// File: rtl/phasor_apb_regs.sv
// APB slave for the phasor generator: angle register, start pulse, read mux, error flag
`timescale 1ns/1ps

module phasor_apb_regs
    import apb_pkg::*;
    import phasor_pkg::*;
#(
    parameter int ANGLE_BITS = ANGLE_BITS_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    input  result_t  result,
    input  logic     done,
    input  logic     busy,
    output apb_rsp_t apb_rsp,
    output logic     start,
    output phase_u   angle
);

    logic        access;
    logic        addr_ok;
    logic        angle_wr;
    logic        accept;
    logic [31:0] rdata;

    assign access   = apb_req.psel & apb_req.penable;
    assign angle_wr = access & apb_req.pwrite & (apb_req.paddr == REG_ANGLE);
    // a write during a run is refused
    assign accept   = angle_wr & ~busy;

    always_comb begin
        case (apb_req.paddr)
            REG_ANGLE, REG_STATUS, REG_RESULT: addr_ok = 1'b1;
            default:                           addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start     <= 1'b0;
            angle.raw <= '0;
        end else begin
            start <= accept;
            if (accept) begin
                angle.raw <= apb_req.pwdata[ANGLE_BITS-1:0];
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (apb_req.psel && !apb_req.pwrite) begin
            case (apb_req.paddr)
                REG_ANGLE:  rdata = 32'(angle.raw);
                REG_STATUS: begin
                    rdata[STATUS_DONE] = done;
                    rdata[STATUS_BUSY] = busy;
                end
                REG_RESULT: rdata = result;
                default:    rdata = '0;
            endcase
        end
    end

    // no wait states
    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & (~addr_ok | (angle_wr & busy));
    end

    // busy from the result side must block a second start
    assert property (@(posedge clk) disable iff (reset) start |=> !start);

endmodule

// File: rtl/octant_fold.sv
// octant fold: maps an angle neighbour onto the 0 to 45 degree tables with sign and unity flag
`timescale 1ns/1ps

module octant_fold
    import phasor_pkg::*;
#(
    parameter int ANGLE_BITS = ANGLE_BITS_DEFAULT
) (
    input  phase_u angle,
    input  logic   is_sine,
    input  logic   upper,
    output fold_t  fold
);

    localparam logic [ANGLE_BITS-1:0] QUARTER = 1 << (ANGLE_BITS - 2);
    localparam logic [ANGLE_BITS-3:0] OCT     = 1 << (ANGLE_BITS - 3);

    logic [ANGLE_BITS-1:0] neighbour;
    phase_u                eff;
    logic [ANGLE_BITS-3:0] mirror;

    always_comb begin
        // even neighbours around an odd angle, so the index is always exact
        if (upper) begin
            neighbour = angle.raw + ANGLE_BITS'(angle.raw[0]);
        end else begin
            neighbour = angle.raw - ANGLE_BITS'(angle.raw[0]);
        end

        // sin(a) = cos(quarter turn - a)
        eff.raw = is_sine ? QUARTER - neighbour : neighbour;

        // odd octants run backwards through the table
        if (eff.oct.octant[0]) begin
            mirror = OCT - {1'b0, eff.oct.pos};
        end else begin
            mirror = {1'b0, eff.oct.pos};
        end

        case (eff.oct.octant)
            3'd0: {fold.use_cos, fold.positive} = 2'b11;
            3'd1: {fold.use_cos, fold.positive} = 2'b01;
            3'd2: {fold.use_cos, fold.positive} = 2'b00;
            3'd3: {fold.use_cos, fold.positive} = 2'b10;
            3'd4: {fold.use_cos, fold.positive} = 2'b10;
            3'd5: {fold.use_cos, fold.positive} = 2'b00;
            3'd6: {fold.use_cos, fold.positive} = 2'b01;
            default: {fold.use_cos, fold.positive} = 2'b11;
        endcase

        fold.index = mirror[ANGLE_BITS-3:1];
        // cosine of zero does not fit the table
        fold.unity = fold.use_cos & (fold.index == '0);
    end

endmodule

// File: rtl/quarter_table.sv
// cosine and sine octant ROMs with two registered read ports
`timescale 1ns/1ps

module quarter_table
    import phasor_pkg::*;
#(
    parameter int ANGLE_BITS = ANGLE_BITS_DEFAULT
) (
    input  logic        clk,
    input  fold_t       fold_lo,
    input  fold_t       fold_hi,
    output table_word_t word_lo,
    output table_word_t word_hi
);

    localparam int DEPTH     = (1 << (ANGLE_BITS - 4)) + 1;
    localparam int ADDR_BITS = $clog2(2 * DEPTH);

    // cosine octant in the lower half, sine octant in the upper half
    table_word_t rom [0:2*DEPTH-1];

    initial $readmemh("rtl/quarter_table.hex", rom);

    function automatic logic [ADDR_BITS-1:0] rom_addr(fold_t f);
        logic [ADDR_BITS-1:0] base;
        base = f.use_cos ? '0 : ADDR_BITS'(DEPTH);
        return base + ADDR_BITS'(f.index);
    endfunction

    always_ff @(posedge clk) begin
        word_lo <= rom[rom_addr(fold_lo)];
        word_hi <= rom[rom_addr(fold_hi)];
    end

endmodule

// File: rtl/phasor_engine.sv
// phasor engine: issues cosine then sine lookups, signs and averages the neighbour pair
`timescale 1ns/1ps

module phasor_engine
    import phasor_pkg::*;
#(
    parameter int ANGLE_BITS = ANGLE_BITS_DEFAULT
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  phase_u  angle,
    output logic    sample_valid,
    output logic    is_sine,
    output sample_t sample
);

    logic              sin_issue;
    logic              issue;
    logic              stage1_valid;
    fold_t             fold_lo;
    fold_t             fold_hi;
    table_word_t       word_lo;
    table_word_t       word_hi;
    lookup_t           lookup_q;
    logic signed [16:0] sum;

    function automatic logic signed [16:0] signed_word(table_word_t w, fold_t f);
        logic signed [16:0] v;
        v = {2'b00, w};
        if (f.unity) begin
            v[14] = 1'b1;
        end
        return f.positive ? v : -v;
    endfunction

    // cosine slot on start, sine slot right after
    assign issue = start | sin_issue;

    octant_fold #(.ANGLE_BITS(ANGLE_BITS)) fold_lo_inst (
        .angle   (angle),
        .is_sine (sin_issue),
        .upper   (1'b0),
        .fold    (fold_lo)
    );

    octant_fold #(.ANGLE_BITS(ANGLE_BITS)) fold_hi_inst (
        .angle   (angle),
        .is_sine (sin_issue),
        .upper   (1'b1),
        .fold    (fold_hi)
    );

    quarter_table #(.ANGLE_BITS(ANGLE_BITS)) quarter_table_inst (
        .clk     (clk),
        .fold_lo (fold_lo),
        .fold_hi (fold_hi),
        .word_lo (word_lo),
        .word_hi (word_hi)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin_issue    <= 1'b0;
            stage1_valid <= 1'b0;
            lookup_q     <= '0;
            sample_valid <= 1'b0;
            is_sine      <= 1'b0;
        end else begin
            sin_issue    <= start;
            stage1_valid <= issue;
            lookup_q     <= '{lo: fold_lo, hi: fold_hi, is_sine: sin_issue};
            sample_valid <= stage1_valid;
            is_sine      <= lookup_q.is_sine;
        end
    end

    // half-step interpolation
    assign sum = signed_word(word_lo, lookup_q.lo) + signed_word(word_hi, lookup_q.hi);

    always_ff @(posedge clk) begin
        sample <= sum[16:1];
    end

    // cosine sample two cycles after start, sine sample the cycle after
    assert property (@(posedge clk) disable iff (reset)
        $past(start, 2) |-> sample_valid && !is_sine);
    assert property (@(posedge clk) disable iff (reset)
        $past(start, 3) |-> sample_valid && is_sine);

endmodule

// File: rtl/phasor_result.sv
// result capture: stores cosine into re and sine into im, tracks busy and done
`timescale 1ns/1ps

module phasor_result
    import phasor_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  logic    sample_valid,
    input  logic    is_sine,
    input  sample_t sample,
    output result_t result,
    output logic    done,
    output logic    busy
);

    logic done_q;
    logic busy_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            done_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end
            if (sample_valid) begin
                if (is_sine) begin
                    result.im <= sample;
                    busy_q    <= 1'b0;
                    done_q    <= 1'b1;
                end else begin
                    result.re <= sample;
                end
            end
        end
    end

    // a new run shows as busy, and hides the old done, from its first cycle
    assign busy = busy_q | start;
    assign done = done_q & ~start;

    // samples arrive only during a run
    assert property (@(posedge clk) disable iff (reset) sample_valid |-> busy_q);

endmodule

// File: rtl/phasor_top.sv
// phasor generator top level: APB register block, engine and result capture
`timescale 1ns/1ps

module phasor_top
    import apb_pkg::*;
    import phasor_pkg::*;
#(
    parameter int ANGLE_BITS = ANGLE_BITS_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    phase_u  angle;
    logic    start;
    logic    sample_valid;
    logic    is_sine;
    sample_t sample;
    result_t result;
    logic    done;
    logic    busy;

    phasor_apb_regs #(.ANGLE_BITS(ANGLE_BITS)) phasor_apb_regs_inst (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .result  (result),
        .done    (done),
        .busy    (busy),
        .apb_rsp (apb_rsp),
        .start   (start),
        .angle   (angle)
    );

    phasor_engine #(.ANGLE_BITS(ANGLE_BITS)) phasor_engine_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .angle        (angle),
        .sample_valid (sample_valid),
        .is_sine      (is_sine),
        .sample       (sample)
    );

    phasor_result phasor_result_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .sample_valid (sample_valid),
        .is_sine      (is_sine),
        .sample       (sample),
        .result       (result),
        .done         (done),
        .busy         (busy)
    );

endmodule

// File: bench/tb_phasor_tasks.svh
// APB access tasks, typed compare tasks and the phasor reference model

// no wait states, so pready is high in every access phase
task automatic check_ready(input logic [3:0] addr);
    checks++;
    if (apb_rsp.pready !== 1'b1) begin
        $display("pready was low in the access phase at offset %h", addr);
        errors++;
    end
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // response is stable in the middle of the access phase
    @(negedge clk);
    err = apb_rsp.pslverr;
    check_ready(addr);
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_ready(addr);
    @(posedge clk);
    #1;
    apb_req = '0;
endtask

task automatic wait_done(input string name);
    logic [31:0] status;
    logic        err;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[STATUS_DONE] && polls < 20) begin
        apb_read(REG_STATUS, status, err);
        polls++;
    end
    if (!status[STATUS_DONE]) begin
        $display("%s: timeout, done was not set after 20 status reads", name);
        errors++;
    end
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    checks++;
    if (act !== exp) begin
        $display("** Error: %s: expected %0d, actual %0d", name, exp, act);
        errors++;
    end
endtask

task automatic check_result(input string name, input result_t exp, input result_t act);
    checks++;
    if (act !== exp) begin
        $display("** Error: %s: expected (%0d, %0d), actual (%0d, %0d)",
                 name, exp.re, exp.im, act.re, act.im);
        errors++;
    end
endtask

// within 3 LSB of the model
task automatic check_near(input string name, input sample_t exp, input sample_t act);
    int diff;
    checks++;
    diff = int'(act) - int'(exp);
    if (diff > 3 || diff < -3) begin
        $display("** Error: %s: expected %0d, actual %0d", name, exp, act);
        errors++;
    end
endtask

task automatic check_err(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        $display("** Error: %s: expected pslverr %0b, actual %0b", name, exp, act);
        errors++;
    end
endtask

// busy in bit 1, done in bit 0
task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
        $display("** Error: %s: expected status %b, actual %b", name, exp, act);
        errors++;
    end
endtask

task automatic check_angle(input string name, input phase_u exp, input phase_u act);
    checks++;
    if (act !== exp) begin
        $display("** Error: %s: expected angle %0d, actual %0d", name, exp.raw, act.raw);
        errors++;
    end
endtask

function automatic sample_t model_sample(input logic [8:0] a, input logic is_sine);
    real phi;
    real v;
    int  r;
    phi = 2.0 * 3.14159265358979 * real'(a) / 512.0;
    v   = 16384.0 * (is_sine ? $sin(phi) : $cos(phi));
    r   = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
    return sample_t'(r);
endfunction

// File: bench/tb_phasor.sv
// phasor generator testbench: clock, reset, DUT, random angles and directed test sequence
`timescale 1ns/1ps

module tb_phasor
    import apb_pkg::*;
    import phasor_pkg::*;
();

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    int          errors;
    int          checks;
    logic [31:0] rng_state;

    phasor_top #(.ANGLE_BITS(9)) phasor_top_inst (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    `include "tb_phasor_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [8:0] random_angle();
        rng_state = xorshift32(rng_state);
        return rng_state[8:0];
    endfunction

    // one full run: write, wait for done, read the pair back
    task automatic compute_phasor(input string name, input logic [8:0] a, output result_t r);
        logic        err;
        logic [31:0] data;
        apb_write(REG_ANGLE, 32'(a), err);
        check_err({name, " write"}, 1'b0, err);
        wait_done(name);
        apb_read(REG_RESULT, data, err);
        r = result_t'(data);
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        logic        err;
        apb_read(REG_STATUS, data, err);
        check_err("reset status read", 1'b0, err);
        check_status("reset status", 2'b00, data[1:0]);
        apb_read(REG_RESULT, data, err);
        check_result("reset result", '0, result_t'(data));
    endtask

    task automatic test_axes();
        result_t r;
        result_t exp;
        for (int q = 0; q < 4; q++) begin
            case (q)
                0: exp = '{re: 16'sd16384, im: 16'sd0};
                1: exp = '{re: 16'sd0, im: 16'sd16384};
                2: exp = '{re: -16'sd16384, im: 16'sd0};
                default: exp = '{re: 16'sd0, im: -16'sd16384};
            endcase
            compute_phasor("axes", 9'(q * 128), r);
            check_result($sformatf("axes angle %0d", q * 128), exp, r);
        end
    endtask

    // accepted write edge is cycle 0, each read samples in its access cycle
    task automatic test_timing();
        logic [31:0] data;
        logic        err;
        apb_write(REG_ANGLE, 32'd37, err);
        check_err("timing write", 1'b0, err);
        @(posedge clk);
        #1;
        apb_read(REG_STATUS, data, err);
        check_status("timing cycle 3", 2'b10, data[1:0]);
        apb_read(REG_STATUS, data, err);
        check_status("timing cycle 5", 2'b01, data[1:0]);
        apb_read(REG_STATUS, data, err);
        check_status("timing cycle 7", 2'b01, data[1:0]);
        // second run one cycle earlier, so cycles 2 and 4 are seen too
        apb_write(REG_ANGLE, 32'd37, err);
        check_err("timing second write", 1'b0, err);
        apb_read(REG_STATUS, data, err);
        check_status("timing cycle 2", 2'b10, data[1:0]);
        apb_read(REG_STATUS, data, err);
        check_status("timing cycle 4", 2'b10, data[1:0]);
    endtask

    task automatic test_accuracy();
        logic [8:0] a;
        result_t    r;
        for (int i = 0; i < 40; i++) begin
            a = random_angle();
            compute_phasor("accuracy", a, r);
            check_near($sformatf("accuracy re %0d", a), model_sample(a, 1'b0), r.re);
            check_near($sformatf("accuracy im %0d", a), model_sample(a, 1'b1), r.im);
        end
    endtask

    task automatic test_symmetry();
        logic [8:0] a;
        result_t    ra;
        result_t    rb;
        for (int i = 0; i < 10; i++) begin
            a = random_angle();
            compute_phasor("symmetry", a, ra);
            compute_phasor("symmetry", 9'd128 - a, rb);
            check_sample($sformatf("symmetry %0d", a), rb.re, ra.im);
        end
    endtask

    task automatic test_errors();
        result_t     exp;
        logic [31:0] data;
        logic        err;
        exp = '{re: 16'sd0, im: 16'sd16384};
        apb_write(REG_ANGLE, 32'd128, err);
        check_err("errors first write", 1'b0, err);
        apb_write(REG_ANGLE, 32'd77, err);
        check_err("errors write while busy", 1'b1, err);
        wait_done("errors");
        apb_read(REG_RESULT, data, err);
        check_result("errors result kept", exp, result_t'(data));
        apb_read(REG_ANGLE, data, err);
        check_angle("errors angle kept", 9'd128, data[8:0]);
        apb_read(4'hC, data, err);
        check_err("errors read 0xC", 1'b1, err);
        check_result("errors read 0xC data", '0, result_t'(data));
        apb_write(4'hC, 32'h1234, err);
        check_err("errors write 0xC", 1'b1, err);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        rng_state = 32'd50;
        reset     = 1'b1;
        apb_req   = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_axes();
        test_timing();
        test_accuracy();
        test_symmetry();
        test_errors();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+bench
rtl/phasor_pkg.sv
rtl/apb_pkg.sv
rtl/phasor_apb_regs.sv
rtl/octant_fold.sv
rtl/quarter_table.sv
rtl/phasor_engine.sv
rtl/phasor_result.sv
rtl/phasor_top.sv
bench/tb_phasor.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_phasor
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/quarter_table.hex
0000
3FFB
3FEC
3FD4
3FB1
3F85
3F4F
3F0F
3EC5
3E72
3E15
3DAF
3D3F
3CC5
3C42
3BB6
3B21
3A82
39DB
392B
3871
37B0
36E5
3612
3537
3453
3368
3274
3179
3076
2F6C
2E5A
2D41
0000
0192
0324
04B5
0646
07D6
0964
0AF1
0C7C
0E06
0F8D
1112
1294
1413
1590
1709
187E
19EF
1B5D
1CC6
1E2B
1F8C
20E7
223D
238E
24DA
2620
2760
289A
29CE
2AFB
2C21
2D41
